/* tb/exc_stim.txt */
# ctl flags pc vaddr asid(if,mm) hw_int mtc0_addr mtc0_data mfc0_addr, then flush new_pc code mfc0_data
# ctl bits: 0 valid, 1 real, 2 delay slot, 3 store, 4 if_exl, 5 mm_exl, 6 special vec, 7 mtc0_we, 8 no idle, 9 check mfc0
# flags bit 12 down to 0 in priority order, iaddr_illegal first and daddr_dirty last; code ff is not checked
203 0000 80000000 00000000 0000 00 00 00000000 0c 0 00000000 ff 00400002
003 1fff 80001000 00000010 0000 00 00 00000000 00 1 bfc00380 04 00000000
233 0fff 80001004 00000010 1234 00 00 00000000 08 1 bfc00380 02 80001000
233 03ff 80001008 00000010 1234 00 00 00000000 0a 1 bfc00380 08 00000012
233 01ff 8000100c 00000000 0000 00 00 00000000 08 1 bfc00380 09 80001004
233 00ff 80001010 00000000 0000 00 00 00000000 0d 1 bfc00380 0a 00000024
033 007f 80001014 00000000 0000 00 00 00000000 00 1 bfc00380 0b 00000000
033 003f 80001018 00000000 0000 00 00 00000000 00 1 bfc00380 0c 00000000
033 001f 8000101c 00000000 0000 00 00 00000000 00 1 80001018 ff 00000000
20b 000f 80001020 00002001 0000 00 00 00000000 0c 1 bfc00380 05 00400000
23b 0007 80001024 00003000 1256 00 00 00000000 08 1 bfc00380 03 00002001
233 0003 80001028 00004000 0078 00 00 00000000 0a 1 bfc00380 02 00000056
23b 0001 8000102c 00005000 009a 00 00 00000000 0a 1 bfc00380 01 00000078
237 0200 80002004 00000000 0000 00 00 00000000 08 1 bfc00380 08 00005000
233 0000 80002008 00000000 0000 00 00 00000000 0e 0 00000000 ff 80002000
233 0000 8000200c 00000000 0000 00 00 00000000 0d 0 00000000 ff 80000020
080 0000 00000000 00000000 0000 00 0f 80010000 00 0 00000000 ff 00000000
280 0000 00000000 00000000 0000 00 0c 00000002 0f 0 00000000 ff 80010000
233 0080 80003000 00000000 0000 00 00 00000000 0c 1 80010180 0a 00000002
233 0010 80003004 00000000 0000 00 00 00000000 0e 1 80003000 ff 80003000
203 0800 00400000 00000000 bc00 00 00 00000000 0c 1 80010000 02 00000000
233 0004 80003008 00006000 00de 00 00 00000000 0a 1 80010180 02 000000bc
233 0010 80003010 00000000 0000 00 00 00000000 08 1 80003008 ff 00006000
080 0000 00000000 00000000 0000 00 0d 00000100 00 0 00000000 ff 00000000
283 0000 80003014 00000000 0000 00 0c 00000001 0d 0 00000000 ff 00000108
283 0000 80003018 00000000 0000 00 0c 00000101 0c 0 00000000 ff 00000001
203 0000 80004000 00000000 0000 00 00 00000000 0c 1 80010180 00 00000101
2b3 0010 80004004 00000000 0000 00 0d 00000000 0e 1 80004000 ff 80004000
283 0000 80004008 00000000 0000 00 0c 00000401 0d 0 00000000 ff 00000000
2c3 0000 8000400c 00000000 0000 01 00 00000000 0c 0 00000000 ff 00000401
1c3 0000 80004010 00000000 0000 01 00 00000000 00 0 00000000 ff 00000000
1c1 0000 80004014 00000000 0000 01 00 00000000 00 0 00000000 ff 00000000
2c3 0000 80005000 00000000 0000 01 00 00000000 0d 1 80010200 00 00000400

/* list.f */
+incdir+hdl
hdl/mips_arch_pkg.sv
hdl/cp0_pkg.sv
hdl/exc_commit_if.sv
hdl/int_pending.sv
hdl/cp0_regs.sv
hdl/exception.sv
hdl/exc_top.sv
tb/exc_chk.sv
tb/exc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exc_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/exc_tb.sv */
`timescale 1ns/1ps

module exc_tb;

    // One line of the stim file with every column read as a full word
    typedef struct {
        logic [31:0] ctl;
        logic [31:0] flags;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] asid;
        logic [31:0] hw;
        logic [31:0] mtc0_addr;
        logic [31:0] mtc0_data;
        logic [31:0] mfc0_addr;
        logic [31:0] exp_flush;
        logic [31:0] exp_pc;
        logic [31:0] exp_code;
        logic [31:0] exp_mfc0;
    } vector_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_valid, is_real_inst, in_delayslot, data_we;
    logic        iaddr_illegal, iaddr_miss, iaddr_invalid, syscall, break_inst;
    logic        invalid_inst, cpu_unusable, overflow, eret;
    logic        daddr_illegal, daddr_miss, daddr_invalid, daddr_dirty;
    logic        if_exl, mm_exl, special_int_vec, mtc0_we;
    logic [31:0] pc, mem_vaddr, mtc0_data, mfc0_data, new_pc;
    logic [7:0]  if_asid, mm_asid;
    logic [5:0]  hw_int;
    logic [4:0]  mtc0_addr, mfc0_addr, exc_code;
    logic        flush;

    vector_t vecs[$];
    int      errors = 0;
    int      cycles = 0;
    int      limit = 0;
    int      cur = 0;
    integer  seed = 32'h1525aad6;

    exc_top exc_top_i (.*);

    bind exc_top exc_chk exc_chk_i (
        .clk, .rst, .inst_valid, .flush,
        .wr_exp (commit.wr_exp), .badv_we (commit.badv_we), .status_exl
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: vector %0d %s is %h, expected %h",
                     $time, cur + 1, what, got, expected);
        end
    endtask

    task automatic drive_vector(input vector_t v);
        inst_valid      = v.ctl[0];
        is_real_inst    = v.ctl[1];
        in_delayslot    = v.ctl[2];
        data_we         = v.ctl[3];
        if_exl          = v.ctl[4];
        mm_exl          = v.ctl[5];
        special_int_vec = v.ctl[6];
        mtc0_we         = v.ctl[7];
        {iaddr_illegal, iaddr_miss, iaddr_invalid, syscall, break_inst, invalid_inst,
         cpu_unusable, overflow, eret, daddr_illegal, daddr_miss, daddr_invalid,
         daddr_dirty} = v.flags[12:0];  // Highest priority in bit 12
        pc        = v.pc;
        mem_vaddr = v.vaddr;
        if_asid   = v.asid[15:8];
        mm_asid   = v.asid[7:0];
        hw_int    = v.hw[5:0];
        mtc0_addr = v.mtc0_addr[4:0];
        mtc0_data = v.mtc0_data;
        mfc0_addr = v.mfc0_addr[4:0];
    endtask

    task automatic load_stimulus();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        fd = $fopen("tb/exc_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file tb/exc_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v.ctl, v.flags, v.pc, v.vaddr, v.asid, v.hw, v.mtc0_addr,
                            v.mtc0_data, v.mfc0_addr, v.exp_flush, v.exp_pc,
                            v.exp_code, v.exp_mfc0);
                if (n == 13) begin
                    vecs.push_back(v);
                end else begin
                    errors++;
                    $display("stimulus line has %0d of 13 columns: %s", n, line);
                end
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            errors++;
            $display("no test vectors found in tb/exc_stim.txt");
        end
    endtask

    task automatic run_vector(input vector_t v);
        int n_idle;
        n_idle = v.ctl[8] ? 0 : {$random(seed)} % 3;  // Bit 8 keeps pin timing exact
        repeat (n_idle) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            mtc0_we    = 1'b0;
            @(negedge clk);
            check("idle flush", {31'b0, flush}, 32'd0);
        end
        @(posedge clk);
        #1;
        drive_vector(v);
        @(negedge clk);
        check("flush", {31'b0, flush}, v.exp_flush);
        if (v.exp_flush[0]) begin
            check("new_pc", new_pc, v.exp_pc);
            if (v.exp_code != 32'hff)
                check("exc_code", {27'b0, exc_code}, v.exp_code);
        end
        if (v.ctl[9])
            check("mfc0_data", mfc0_data, v.exp_mfc0);
    endtask

    task automatic finish_run();
        int asrt;
        asrt = exc_top_i.exc_chk_i.flush_fails + exc_top_i.exc_chk_i.exl_fails
             + exc_top_i.exc_chk_i.badv_fails;
        $display("%0d vectors, %0d check errors, %0d assertion failures",
                 vecs.size(), errors, asrt);
        if (errors == 0 && asrt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    initial begin
        vector_t idle_vec;
        idle_vec = '{default: '0};
        drive_vector(idle_vec);
        rst = 1'b1;
        load_stimulus();
        limit = vecs.size() * 4 + 50;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        for (cur = 0; cur < vecs.size(); cur++)
            run_vector(vecs[cur]);
        // Let the last commit reach the one-cycle-later EXL property
        repeat (2) @(posedge clk);
        #1;
        finish_run();
    end

endmodule

/* tb/exc_chk.sv */
`timescale 1ns/1ps

module exc_chk (
    input logic clk,
    input logic rst,
    input logic inst_valid,
    input logic flush,
    input logic wr_exp,
    input logic badv_we,
    input logic status_exl
);

    // One failure count per property
    int flush_fails = 0;
    int exl_fails   = 0;
    int badv_fails  = 0;

    flush_needs_valid: assert property (@(posedge clk) disable iff (rst) flush |-> inst_valid)
        else begin
            flush_fails++;
            $error("flush high while inst_valid is low");
        end

    exl_after_commit: assert property (@(posedge clk) disable iff (rst) wr_exp |=> status_exl)
        else begin
            exl_fails++;
            $error("Status.EXL clear in the cycle after an exception commit");
        end

    badv_needs_commit: assert property (@(posedge clk) disable iff (rst) badv_we |-> wr_exp)
        else begin
            badv_fails++;
            $error("badv_we without wr_exp");
        end

endmodule

/* hdl/exc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  logic                        is_real_inst,
    input  mips_arch_pkg::word_t        pc,
    input  mips_arch_pkg::word_t        mem_vaddr,
    input  logic                        in_delayslot,
    input  logic                        iaddr_illegal,
    input  logic                        iaddr_miss,
    input  logic                        iaddr_invalid,
    input  logic                        syscall,
    input  logic                        break_inst,
    input  logic                        invalid_inst,
    input  logic                        cpu_unusable,
    input  logic                        overflow,
    input  logic                        eret,
    input  logic                        daddr_illegal,
    input  logic                        daddr_miss,
    input  logic                        daddr_invalid,
    input  logic                        daddr_dirty,
    input  logic                        data_we,
    input  mips_arch_pkg::asid_t        if_asid,
    input  mips_arch_pkg::asid_t        mm_asid,
    input  logic                        if_exl,
    input  logic                        mm_exl,
    input  logic                        special_int_vec,
    input  logic [5:0]                  hw_int,
    input  logic                        mtc0_we,
    input  cp0_pkg::cp0_reg_t           mtc0_addr,
    input  mips_arch_pkg::word_t        mtc0_data,
    input  cp0_pkg::cp0_reg_t           mfc0_addr,
    output mips_arch_pkg::word_t        mfc0_data,
    output logic                        flush,
    output mips_arch_pkg::word_t        new_pc,
    output mips_arch_pkg::exc_code_t    exc_code
);

    logic                       status_exl;
    logic                       status_ie;
    logic                       status_bev;
    mips_arch_pkg::ebase_t      ebase;
    mips_arch_pkg::word_t       epc_out;
    mips_arch_pkg::int_vec_t    int_mask;
    logic [1:0]                 soft_int;
    logic [5:0]                 hw_ip;
    mips_arch_pkg::int_vec_t    pending;
    logic                       allow_int;

    exc_commit_if commit ();

    exception exception_i (
        .inst_valid, .is_real_inst, .pc, .mem_vaddr, .in_delayslot,
        .iaddr_illegal, .iaddr_miss, .iaddr_invalid,
        .syscall, .break_inst, .invalid_inst, .cpu_unusable, .overflow, .eret,
        .daddr_illegal, .daddr_miss, .daddr_invalid, .daddr_dirty, .data_we,
        .if_asid, .mm_asid, .if_exl, .mm_exl,
        .pending, .allow_int, .status_bev, .special_int_vec, .ebase, .epc_out,
        .flush, .new_pc, .exc_code,
        .commit (commit)
    );

    cp0_regs cp0_regs_i (
        .clk, .rst,
        .mtc0_we, .mtc0_addr, .mtc0_data, .mfc0_addr, .hw_ip,
        .commit (commit),
        .mfc0_data, .status_exl, .status_ie, .status_bev,
        .ebase, .epc_out, .int_mask, .soft_int
    );

    int_pending int_pending_i (
        .clk, .rst, .hw_int, .soft_int, .int_mask, .status_ie, .status_exl,
        .hw_ip, .pending, .allow_int
    );

endmodule

/* hdl/exception.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exc_settings.svh"

module exception (
    input  logic                        inst_valid,
    input  logic                        is_real_inst,
    input  mips_arch_pkg::word_t        pc,
    input  mips_arch_pkg::word_t        mem_vaddr,
    input  logic                        in_delayslot,
    input  logic                        iaddr_illegal,
    input  logic                        iaddr_miss,
    input  logic                        iaddr_invalid,
    input  logic                        syscall,
    input  logic                        break_inst,
    input  logic                        invalid_inst,
    input  logic                        cpu_unusable,
    input  logic                        overflow,
    input  logic                        eret,
    input  logic                        daddr_illegal,
    input  logic                        daddr_miss,
    input  logic                        daddr_invalid,
    input  logic                        daddr_dirty,
    input  logic                        data_we,
    input  mips_arch_pkg::asid_t        if_asid,
    input  mips_arch_pkg::asid_t        mm_asid,
    input  logic                        if_exl,
    input  logic                        mm_exl,
    input  mips_arch_pkg::int_vec_t     pending,
    input  logic                        allow_int,
    input  logic                        status_bev,
    input  logic                        special_int_vec,
    input  mips_arch_pkg::ebase_t       ebase,
    input  mips_arch_pkg::word_t        epc_out,
    output logic                        flush,
    output mips_arch_pkg::word_t        new_pc,
    output mips_arch_pkg::exc_code_t    exc_code,
    exc_commit_if.ctrl                  commit
);

    mips_arch_pkg::word_t exc_base;
    logic                 take_int;

    assign exc_base = status_bev ? `BOOT_EXC_VEC : {ebase, 12'b0};
    assign take_int = is_real_inst && allow_int && (pending != '0);

    assign commit.epc = in_delayslot ? (pc - 32'd4) : pc;
    assign commit.bd  = in_delayslot;
    assign commit.code = exc_code;

    always_comb begin
        flush             = 1'b0;
        commit.wr_exp     = 1'b0;
        commit.clean_exl  = 1'b0;
        commit.badv_we    = 1'b0;
        commit.bad_vaddr  = '0;
        commit.asid_we    = 1'b0;
        commit.asid       = '0;
        exc_code          = mips_arch_pkg::EXC_INT;
        new_pc            = exc_base + `VEC_GENERAL;
        if (inst_valid) begin
            flush         = 1'b1;
            commit.wr_exp = 1'b1;
            if (take_int) begin
                if (special_int_vec)
                    new_pc = exc_base + `VEC_SPECIAL_INT;
            end else if (iaddr_illegal) begin
                commit.bad_vaddr = pc;
                commit.badv_we   = 1'b1;
                exc_code         = mips_arch_pkg::EXC_ADEL;
            end else if (iaddr_miss || iaddr_invalid) begin
                if (iaddr_miss && !if_exl)
                    new_pc = exc_base + `VEC_REFILL;  // Refill only outside EXL
                commit.bad_vaddr = pc;
                commit.badv_we   = 1'b1;
                commit.asid      = if_asid;
                commit.asid_we   = 1'b1;
                exc_code         = mips_arch_pkg::EXC_TLBL;
            end else if (syscall) begin
                exc_code = mips_arch_pkg::EXC_SYS;
            end else if (break_inst) begin
                exc_code = mips_arch_pkg::EXC_BP;
            end else if (invalid_inst) begin
                exc_code = mips_arch_pkg::EXC_RI;
            end else if (cpu_unusable) begin
                exc_code = mips_arch_pkg::EXC_CPU;
            end else if (overflow) begin
                exc_code = mips_arch_pkg::EXC_OV;
            end else if (eret) begin
                // Return path records no state
                commit.wr_exp    = 1'b0;
                commit.clean_exl = 1'b1;
                new_pc           = epc_out;
            end else if (daddr_illegal) begin
                commit.bad_vaddr = mem_vaddr;
                commit.badv_we   = 1'b1;
                exc_code = data_we ? mips_arch_pkg::EXC_ADES : mips_arch_pkg::EXC_ADEL;
            end else if (daddr_miss || daddr_invalid) begin
                if (daddr_miss && !mm_exl)
                    new_pc = exc_base + `VEC_REFILL;
                commit.bad_vaddr = mem_vaddr;
                commit.badv_we   = 1'b1;
                commit.asid      = mm_asid;
                commit.asid_we   = 1'b1;
                exc_code = data_we ? mips_arch_pkg::EXC_TLBS : mips_arch_pkg::EXC_TLBL;
            end else if (daddr_dirty) begin
                commit.bad_vaddr = mem_vaddr;
                commit.badv_we   = 1'b1;
                commit.asid      = mm_asid;
                commit.asid_we   = 1'b1;
                exc_code         = mips_arch_pkg::EXC_MOD;  // Store to clean page
            end else begin
                flush         = 1'b0;
                commit.wr_exp = 1'b0;
            end
        end
    end

endmodule

/* hdl/cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mtc0_we,
    input  cp0_pkg::cp0_reg_t           mtc0_addr,
    input  mips_arch_pkg::word_t        mtc0_data,
    input  cp0_pkg::cp0_reg_t           mfc0_addr,
    input  logic [5:0]                  hw_ip,
    exc_commit_if.regs                  commit,
    output mips_arch_pkg::word_t        mfc0_data,
    output logic                        status_exl,
    output logic                        status_ie,
    output logic                        status_bev,
    output mips_arch_pkg::ebase_t       ebase,
    output mips_arch_pkg::word_t        epc_out,
    output mips_arch_pkg::int_vec_t     int_mask,
    output logic [1:0]                  soft_int
);

    logic                       st_bev;
    logic                       st_exl;
    logic                       st_ie;
    mips_arch_pkg::int_vec_t    st_im;
    logic                       ca_bd;
    logic [1:0]                 ca_ip_sw;  // Software interrupt bits
    mips_arch_pkg::exc_code_t   ca_exc;
    mips_arch_pkg::word_t       epc_q;
    mips_arch_pkg::word_t       badvaddr_q;
    logic [18:0]                ehi_vpn2;
    mips_arch_pkg::asid_t       ehi_asid;
    mips_arch_pkg::ebase_t      ebase_q;
    mips_arch_pkg::word_t       status_rd;
    mips_arch_pkg::word_t       cause_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            st_bev     <= 1'b1;
            st_exl     <= 1'b1;
            st_ie      <= 1'b0;
            st_im      <= '0;
            ca_bd      <= 1'b0;
            ca_ip_sw   <= '0;
            ca_exc     <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
            ehi_vpn2   <= '0;
            ehi_asid   <= '0;
            ebase_q    <= '0;
        end else begin
            if (mtc0_we) begin
                case (mtc0_addr)
                    cp0_pkg::CP0_STATUS: begin
                        st_bev <= mtc0_data[cp0_pkg::ST_BEV];
                        st_im  <= mtc0_data[cp0_pkg::ST_IM +: 8];
                        st_exl <= mtc0_data[cp0_pkg::ST_EXL];
                        st_ie  <= mtc0_data[cp0_pkg::ST_IE];
                    end
                    cp0_pkg::CP0_CAUSE:   ca_ip_sw <= mtc0_data[cp0_pkg::CA_IP +: 2];
                    cp0_pkg::CP0_EPC:     epc_q    <= mtc0_data;
                    cp0_pkg::CP0_ENTRYHI: begin
                        ehi_vpn2 <= mtc0_data[31:13];
                        ehi_asid <= mtc0_data[7:0];
                    end
                    cp0_pkg::CP0_EBASE:   ebase_q  <= mtc0_data[31:12];
                    default: ;  // BadVAddr is read only
                endcase
            end
            // Exception commit wins over a same-cycle mtc0
            if (commit.wr_exp) begin
                st_exl <= 1'b1;
                ca_bd  <= commit.bd;
                ca_exc <= commit.code;
                epc_q  <= commit.epc;
                if (commit.badv_we)
                    badvaddr_q <= commit.bad_vaddr;
                if (commit.asid_we)
                    ehi_asid <= commit.asid;
            end else if (commit.clean_exl) begin
                st_exl <= 1'b0;
            end
        end
    end

    always_comb begin
        status_rd = '0;
        status_rd[cp0_pkg::ST_BEV]    = st_bev;
        status_rd[cp0_pkg::ST_IM +: 8] = st_im;
        status_rd[cp0_pkg::ST_EXL]    = st_exl;
        status_rd[cp0_pkg::ST_IE]     = st_ie;
        cause_rd = '0;
        cause_rd[cp0_pkg::CA_BD]      = ca_bd;
        cause_rd[cp0_pkg::CA_IP +: 8] = {hw_ip, ca_ip_sw};  // IP[7:2] tracks the pins
        cause_rd[cp0_pkg::CA_EXC +: 5] = ca_exc;
    end

    always_comb begin
        case (mfc0_addr)
            cp0_pkg::CP0_BADVADDR: mfc0_data = badvaddr_q;
            cp0_pkg::CP0_ENTRYHI:  mfc0_data = {ehi_vpn2, 5'b0, ehi_asid};
            cp0_pkg::CP0_STATUS:   mfc0_data = status_rd;
            cp0_pkg::CP0_CAUSE:    mfc0_data = cause_rd;
            cp0_pkg::CP0_EPC:      mfc0_data = epc_q;
            cp0_pkg::CP0_EBASE:    mfc0_data = {ebase_q, 12'b0};
            default:               mfc0_data = '0;
        endcase
    end

    assign status_exl = st_exl;
    assign status_ie  = st_ie;
    assign status_bev = st_bev;
    assign ebase      = ebase_q;
    assign epc_out    = epc_q;
    assign int_mask   = st_im;
    assign soft_int   = ca_ip_sw;

endmodule

/* hdl/int_pending.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exc_settings.svh"

module int_pending (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [5:0]                  hw_int,
    input  logic [1:0]                  soft_int,
    input  mips_arch_pkg::int_vec_t     int_mask,
    input  logic                        status_ie,
    input  logic                        status_exl,
    output logic [5:0]                  hw_ip,
    output mips_arch_pkg::int_vec_t     pending,
    output logic                        allow_int
);

    // Stage 0 samples the raw pins
    logic [`INT_SYNC_STAGES-1:0][5:0] sync_q;

    always_ff @(posedge clk) begin
        if (rst)
            sync_q <= '0;
        else
            sync_q <= {sync_q[`INT_SYNC_STAGES-2:0], hw_int};
    end

    assign hw_ip = sync_q[`INT_SYNC_STAGES-1];

    // Masked by Status.IM
    assign pending = {hw_ip, soft_int} & int_mask;

    assign allow_int = status_ie && !status_exl;

endmodule

/* hdl/exc_commit_if.sv */
`timescale 1ns/1ps

interface exc_commit_if;

    logic                   wr_exp;     // Record a real exception
    logic                   clean_exl;  // ERET
    mips_arch_pkg::word_t   epc;
    mips_arch_pkg::exc_code_t code;
    logic                   bd;
    mips_arch_pkg::word_t   bad_vaddr;
    logic                   badv_we;
    mips_arch_pkg::asid_t   asid;
    logic                   asid_we;

    modport ctrl (
        output wr_exp, clean_exl,
        output epc, code, bd,
        output bad_vaddr, badv_we,
        output asid, asid_we
    );

    modport regs (
        input wr_exp, clean_exl,
        input epc, code, bd,
        input bad_vaddr, badv_we,
        input asid, asid_we
    );

endinterface

/* hdl/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [4:0] cp0_reg_t;

    // Register numbers with EBase at sel 1 of reg 15
    localparam cp0_reg_t CP0_BADVADDR = 5'd8;
    localparam cp0_reg_t CP0_ENTRYHI  = 5'd10;
    localparam cp0_reg_t CP0_STATUS   = 5'd12;
    localparam cp0_reg_t CP0_CAUSE    = 5'd13;
    localparam cp0_reg_t CP0_EPC      = 5'd14;
    localparam cp0_reg_t CP0_EBASE    = 5'd15;

    // Status fields
    localparam int ST_IE  = 0;
    localparam int ST_EXL = 1;
    localparam int ST_IM  = 8;  // Low bit of IM[7:0]
    localparam int ST_BEV = 22;

    // Cause fields
    localparam int CA_EXC = 2;  // Low bit of ExcCode
    localparam int CA_IP  = 8;  // Low bit of IP[7:0]
    localparam int CA_BD  = 31;

endpackage

/* hdl/mips_arch_pkg.sv */
package mips_arch_pkg;

    typedef logic [31:0] word_t;     // Address or data word
    typedef logic [7:0]  asid_t;
    typedef logic [4:0]  exc_code_t; // Cause.ExcCode
    typedef logic [7:0]  int_vec_t;  // {hw[5:0], sw[1:0]}
    typedef logic [19:0] ebase_t;    // EBase[31:12]

    // Architectural ExcCode encodings
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_RI   = 5'd10;
    localparam exc_code_t EXC_CPU  = 5'd11;
    localparam exc_code_t EXC_OV   = 5'd12;

endpackage

/* hdl/exc_settings.svh */
`ifndef EXC_SETTINGS_SVH
`define EXC_SETTINGS_SVH

// Vector base while Status.BEV is set
`define BOOT_EXC_VEC      32'hBFC0_0200

// Offsets added to the vector base
`define VEC_REFILL        32'h0000_0000
`define VEC_GENERAL       32'h0000_0180
`define VEC_SPECIAL_INT   32'h0000_0200

// Flops on each hardware interrupt pin
`define INT_SYNC_STAGES   2

`endif
